//--- common/tracer_consts.svh
`ifndef TRACER_CONSTS_SVH
`define TRACER_CONSTS_SVH

// fixed-point value width.
`define WORD_BITS        32

`define RAY_WORDS        6          // origin xyz, direction xyz.
`define TRI_WORDS        12         // three vertices and a normal.
`define INSTR_WORDS      18         // ray words followed by triangle words.

`define TRI_COUNT        5          // triangles streamed per ray.

`define MEM_ADDR_BITS    12         // triangle index width.
`define WB_ADR_BITS      16         // triangle index plus 4-bit word select.

`define RAY_FIFO_DEPTH   4
`define INSTR_FIFO_DEPTH 8

`endif

//--- common/tracer_pkg.sv
`include "tracer_consts.svh"

package tracer_pkg;

    typedef logic signed [`WORD_BITS-1:0] word_t;

    // word 0 sits in the low bits of every packed vector.
    typedef logic [`RAY_WORDS*`WORD_BITS-1:0] ray_t;
    typedef logic [`TRI_WORDS*`WORD_BITS-1:0] tri_t;
    typedef logic [`INSTR_WORDS*`WORD_BITS-1:0] instr_t;  // ray in words 0-5.

    typedef logic [`MEM_ADDR_BITS-1:0] tri_addr_t;
    typedef logic [`WB_ADR_BITS-1:0] wb_adr_t;

    typedef enum logic [1:0] {
        idle,
        load_ray,
        fetch_tri,
        emit
    } streamer_state_t;

endpackage

//--- rtl/stream_fifo.sv
module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clock,
    input  logic             reset,

    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,

    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;
    logic push;
    logic pop;

    function automatic logic [PTR_BITS-1:0] bump(input logic [PTR_BITS-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign push  = wr_en && !full;   // push while full is dropped.
    assign pop   = rd_en && !empty;

    assign rd_data = mem[rd_ptr];    // head shown without a read cycle.

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- rtl/tri_mem.sv
`include "tracer_consts.svh"

module tri_mem
    import tracer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_adr_t   wb_adr,
    input  word_t     wb_dat_w,
    output word_t     wb_dat_r,
    output logic      wb_ack,

    input  tri_addr_t tri_addr,
    output tri_t      tri_data
);

    localparam int TRI_DEPTH = 2 ** `MEM_ADDR_BITS;

    tri_addr_t wb_tri;
    logic [3:0] wb_sel;
    logic wb_strobe;
    logic [3:0] sel_q;
    word_t wb_lane [`TRI_WORDS];

    assign wb_tri    = wb_adr[`WB_ADR_BITS-1:4];
    assign wb_sel    = wb_adr[3:0];
    assign wb_strobe = wb_cyc && wb_stb && !wb_ack;   // new strobe only.

    // one lane per triangle word; the host writes single words,
    // the streamer reads all lanes at the same index.
    for (genvar i = 0; i < `TRI_WORDS; i++) begin : g_lane
        word_t lane [TRI_DEPTH];
        word_t rd_tri;
        word_t rd_wb;

        always_ff @(posedge clock) begin
            if (wb_strobe && wb_we && (wb_sel == 4'(i))) begin
                lane[wb_tri] <= wb_dat_w;
            end
            if (wb_strobe) begin
                rd_wb <= lane[wb_tri];
            end
            rd_tri <= lane[tri_addr];
        end

        assign tri_data[i*`WORD_BITS +: `WORD_BITS] = rd_tri;
        assign wb_lane[i] = rd_wb;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
            sel_q  <= '0;
        end else begin
            wb_ack <= wb_strobe;   // single-cycle ack.
            if (wb_strobe) begin
                sel_q <= wb_sel;
            end
        end
    end

    always_comb begin
        wb_dat_r = '0;   // selects 12 to 15 read zero.
        if (sel_q < 4'(`TRI_WORDS)) begin
            wb_dat_r = wb_lane[sel_q];
        end
    end

endmodule

//--- streamer/streamer.sv
`include "tracer_consts.svh"

module streamer
    import tracer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // ray FIFO side.
    input  logic      ray_empty,
    output logic      ray_rd_en,
    input  ray_t      ray_in,

    // instruction FIFO side.
    input  logic      instr_full,
    output logic      instr_wr_en,
    output instr_t    instr_word,

    // triangle memory side.
    output tri_addr_t tri_addr,
    input  tri_t      tri_data
);

    localparam int RAY_BITS   = `RAY_WORDS * `WORD_BITS;
    localparam int INSTR_BITS = `INSTR_WORDS * `WORD_BITS;
    localparam tri_addr_t TRI_END = `TRI_COUNT;

    streamer_state_t state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= idle;
            ray_rd_en   <= 1'b0;
            instr_wr_en <= 1'b0;
            instr_word  <= '0;
            tri_addr    <= '0;
        end else begin
            case (state)
                idle: begin
                    instr_wr_en <= 1'b0;
                    tri_addr    <= '0;
                    if (!ray_empty) begin
                        ray_rd_en <= 1'b1;   // head stays valid until the pop edge.
                        state     <= load_ray;
                    end
                end

                load_ray: begin
                    ray_rd_en                <= 1'b0;
                    instr_word[RAY_BITS-1:0] <= ray_in;
                    state                    <= fetch_tri;
                end

                // tri_data already holds the triangle at tri_addr.
                fetch_tri: begin
                    instr_wr_en                       <= 1'b0;
                    instr_word[INSTR_BITS-1:RAY_BITS] <= tri_data;
                    tri_addr                          <= tri_addr + 1'b1;
                    state                             <= emit;
                end

                emit: begin
                    if (!instr_full) begin
                        instr_wr_en <= 1'b1;
                        if (tri_addr == TRI_END) begin
                            tri_addr <= '0;
                            state    <= idle;
                        end else begin
                            state <= fetch_tri;
                        end
                    end
                end

                default: begin
                    ray_rd_en   <= 1'b0;
                    instr_wr_en <= 1'b0;
                    tri_addr    <= '0;
                    state       <= idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/ray_stream_top.sv
`include "tracer_consts.svh"

module ray_stream_top
    import tracer_pkg::*;
(
    input  logic    clock,
    input  logic    reset,

    // ray input.
    input  logic    ray_wr_en,
    input  ray_t    ray_data,
    output logic    ray_full,

    // host triangle load, Wishbone classic.
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  word_t   wb_dat_w,
    output word_t   wb_dat_r,
    output logic    wb_ack,

    // instruction output.
    input  logic    instr_rd_en,
    output instr_t  instr_data,
    output logic    instr_empty
);

    logic ray_empty;
    logic ray_rd_en;
    ray_t ray_head;

    logic instr_full;
    logic instr_wr_en;
    instr_t instr_word;

    tri_addr_t tri_addr;
    tri_t tri_data;

    stream_fifo #(
        .WIDTH ($bits(ray_t)),
        .DEPTH (`RAY_FIFO_DEPTH)
    ) ray_fifo (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (ray_wr_en),
        .wr_data (ray_data),
        .full    (ray_full),
        .rd_en   (ray_rd_en),
        .rd_data (ray_head),
        .empty   (ray_empty)
    );

    tri_mem i_tri_mem (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .tri_addr (tri_addr),
        .tri_data (tri_data)
    );

    streamer i_streamer (
        .clock       (clock),
        .reset       (reset),
        .ray_empty   (ray_empty),
        .ray_rd_en   (ray_rd_en),
        .ray_in      (ray_head),
        .instr_full  (instr_full),
        .instr_wr_en (instr_wr_en),
        .instr_word  (instr_word),
        .tri_addr    (tri_addr),
        .tri_data    (tri_data)
    );

    stream_fifo #(
        .WIDTH ($bits(instr_t)),
        .DEPTH (`INSTR_FIFO_DEPTH)
    ) instr_fifo (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (instr_wr_en),
        .wr_data (instr_word),
        .full    (instr_full),
        .rd_en   (instr_rd_en),
        .rd_data (instr_data),
        .empty   (instr_empty)
    );

endmodule

//--- tests/ray_stream_sva.sv
`include "tracer_consts.svh"

module ray_stream_sva
    import tracer_pkg::*;
(
    input logic    clock,
    input logic    reset,
    input logic    ray_wr_en,
    input ray_t    ray_data,
    input logic    ray_full,
    input logic    ray_rd_en,
    input logic    wb_cyc,
    input logic    wb_stb,
    input logic    wb_we,
    input wb_adr_t wb_adr,
    input word_t   wb_dat_w,
    input word_t   wb_dat_r,
    input logic    wb_ack,
    input logic    instr_wr_en,
    input logic    instr_full,
    input logic    instr_rd_en,
    input instr_t  instr_data,
    input logic    instr_empty
);

    int fail_count = 0;

    tri_t shadow_tri [`TRI_COUNT];   // triangles as written on the bus.
    ray_t ray_log [16];              // accepted rays in push order.
    logic [3:0] ray_wr_ptr;
    logic [3:0] ray_rd_ptr;
    logic [2:0] tri_idx;             // triangle of the next instruction out.
    logic [2:0] ray_cnt;
    logic read_q;
    word_t exp_rd;
    instr_t exp_instr;
    logic wb_strobe;
    logic ray_push;
    logic ray_pop;
    logic instr_pop;
    tri_addr_t wb_tri;
    logic [3:0] wb_sel;

    assign wb_tri    = wb_adr[`WB_ADR_BITS-1:4];
    assign wb_sel    = wb_adr[3:0];
    assign wb_strobe = wb_cyc && wb_stb && !wb_ack;
    assign ray_push  = ray_wr_en && !ray_full;
    assign ray_pop   = ray_rd_en && (ray_cnt != '0);
    assign instr_pop = instr_rd_en && !instr_empty;
    assign exp_instr = {shadow_tri[tri_idx], ray_log[ray_rd_ptr]};

    always_ff @(posedge clock) begin
        if (wb_strobe && wb_we && (wb_sel < 4'(`TRI_WORDS))
                && (wb_tri < tri_addr_t'(`TRI_COUNT))) begin
            shadow_tri[wb_tri[2:0]][wb_sel*`WORD_BITS +: `WORD_BITS] <= wb_dat_w;
        end
        if (ray_push) begin
            ray_log[ray_wr_ptr] <= ray_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ray_wr_ptr <= '0;
            ray_rd_ptr <= '0;
            tri_idx    <= '0;
            ray_cnt    <= '0;
            read_q     <= 1'b0;
            exp_rd     <= '0;
        end else begin
            read_q <= wb_strobe && !wb_we;
            if (wb_strobe) begin
                exp_rd <= (wb_sel < 4'(`TRI_WORDS)) ?
                    shadow_tri[wb_tri[2:0]][wb_sel*`WORD_BITS +: `WORD_BITS] : '0;
            end
            if (ray_push) begin
                ray_wr_ptr <= ray_wr_ptr + 1'b1;
            end
            case ({ray_push, ray_pop})
                2'b10:   ray_cnt <= ray_cnt + 1'b1;
                2'b01:   ray_cnt <= ray_cnt - 1'b1;
                default: ray_cnt <= ray_cnt;
            endcase
            if (instr_pop) begin
                if (tri_idx == 3'(`TRI_COUNT - 1)) begin
                    tri_idx    <= '0;
                    ray_rd_ptr <= ray_rd_ptr + 1'b1;   // last triangle of this ray.
                end else begin
                    tri_idx <= tri_idx + 1'b1;
                end
            end
        end
    end

    a_wb_read: assert property (@(posedge clock) disable iff (reset)
        (wb_ack && read_q) |-> (wb_dat_r == exp_rd))
        else begin
            fail_count++;
            $error("FAILED wb_read: expected %h, actual %h", $sampled(exp_rd), $sampled(wb_dat_r));
        end

    a_ack_follows: assert property (@(posedge clock) disable iff (reset) wb_strobe |=> wb_ack)
        else begin
            fail_count++;
            $error("wb_ack did not follow a strobe");
        end

    a_ack_single: assert property (@(posedge clock) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack stayed high for more than one cycle");
        end

    a_instr_data: assert property (@(posedge clock) disable iff (reset)
        instr_pop |-> (instr_data == exp_instr))
        else begin
            fail_count++;
            $error("FAILED instr_data: expected %h, actual %h",
                $sampled(exp_instr), $sampled(instr_data));
        end

    a_no_drop: assert property (@(posedge clock) disable iff (reset) instr_wr_en |-> !instr_full)
        else begin
            fail_count++;
            $error("instruction written while the instruction FIFO was full");
        end

    a_ray_full: assert property (@(posedge clock) disable iff (reset)
        ray_full == (ray_cnt == 3'(`RAY_FIFO_DEPTH)))
        else begin
            fail_count++;
            $error("FAILED ray_full: expected %b, actual %b",
                $sampled(ray_cnt == 3'(`RAY_FIFO_DEPTH)), $sampled(ray_full));
        end

    a_reset_state: assert property (@(posedge clock)
        $fell(reset) |-> (instr_empty && !ray_full && !wb_ack && !instr_wr_en))
        else begin
            fail_count++;
            $error("outputs not in their idle state after reset");
        end

endmodule

//--- tests/ray_stream_tb.sv
`include "tracer_consts.svh"

module ray_stream_tb
    import tracer_pkg::*;
();

    localparam int RAY_TOTAL   = 8;
    localparam int INSTR_TOTAL = RAY_TOTAL * `TRI_COUNT;
    localparam int DRAIN_START = 60;      // lets both FIFOs fill first.
    localparam int CYCLE_LIMIT = 20000;   // the phases need a few hundred cycles.

    logic clock;
    logic reset;
    logic ray_wr_en;
    ray_t ray_data;
    logic ray_full;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_adr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;
    logic instr_rd_en;
    instr_t instr_data;
    logic instr_empty;

    logic [31:0] lfsr_state = 32'hf015f5d2;
    int cycle_count = 0;
    int timeouts = 0;
    int check_errors = 0;
    int rays_sent = 0;
    int instr_popped = 0;
    logic saw_full = 1'b0;

    ray_stream_top i_ray_stream_top (
        .clock       (clock),
        .reset       (reset),
        .ray_wr_en   (ray_wr_en),
        .ray_data    (ray_data),
        .ray_full    (ray_full),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .instr_rd_en (instr_rd_en),
        .instr_data  (instr_data),
        .instr_empty (instr_empty)
    );

    bind ray_stream_top ray_stream_sva i_sva (
        .clock (clock), .reset (reset),
        .ray_wr_en (ray_wr_en), .ray_data (ray_data), .ray_full (ray_full),
        .ray_rd_en (ray_rd_en),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .instr_wr_en (instr_wr_en), .instr_full (instr_full),
        .instr_rd_en (instr_rd_en), .instr_data (instr_data), .instr_empty (instr_empty)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic ray_t random_ray();
        ray_t ray;
        for (int i = 0; i < `RAY_WORDS; i++) begin
            ray[i*`WORD_BITS +: `WORD_BITS] = random_bits(32);
        end
        return ray;
    endfunction

    function automatic wb_adr_t wb_address(input int tri_index, input int word_sel);
        return {tri_addr_t'(tri_index), 4'(word_sel)};
    endfunction

    task automatic wb_cycle(input logic we, input wb_adr_t adr, input word_t data);
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        @(posedge clock);
        while (!wb_ack) begin
            @(posedge clock);
        end
        wb_cyc <= 1'b0;   // cycle ends on the ack edge.
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic load_triangles();
        for (int t = 0; t < `TRI_COUNT; t++) begin
            for (int w = 0; w < `TRI_WORDS; w++) begin
                wb_cycle(1'b1, wb_address(t, w), random_bits(32));
            end
        end
        wb_cycle(1'b1, wb_address(2, 13), random_bits(32));   // no lane behind select 13.
        for (int i = 0; i < 8; i++) begin
            wb_cycle(1'b0, wb_address(int'(random_bits(3)) % `TRI_COUNT,
                int'(random_bits(4))), '0);
        end
        for (int w = 12; w < 16; w++) begin
            wb_cycle(1'b0, wb_address(2, w), '0);
        end
    endtask

    // one loop per cycle for both sides keeps the LFSR order fixed.
    task automatic stream_rays();
        int gap;
        int cycle;
        gap = 0;
        cycle = 0;
        forever begin
            @(posedge clock);
            cycle++;
            if (ray_full) saw_full = 1'b1;
            if (ray_wr_en && !ray_full) rays_sent++;
            if (instr_rd_en && !instr_empty) instr_popped++;
            if (instr_popped == INSTR_TOTAL) break;
            if (rays_sent >= RAY_TOTAL) begin
                ray_wr_en <= 1'b0;
            end else if (gap > 0) begin
                gap--;
                ray_wr_en <= 1'b0;
            end else begin
                ray_wr_en <= 1'b1;   // pushes while full are dropped.
                ray_data  <= random_ray();
                if (rays_sent < 3) gap = int'(random_bits(2));
            end
            instr_rd_en <= (cycle >= DRAIN_START) && (random_bits(2) != '0);
        end
        ray_wr_en   <= 1'b0;
        instr_rd_en <= 1'b0;
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = i_ray_stream_top.i_sva.fail_count;
        $display("errors: %0d assertion, %0d check, %0d timeout",
            assert_errors, check_errors, timeouts);
        if (assert_errors == 0 && check_errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            timeouts = timeouts + 1;
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run();
        end
    end

    initial begin
        reset       = 1'b1;
        ray_wr_en   = 1'b0;
        ray_data    = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        instr_rd_en = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        load_triangles();
        stream_rays();

        repeat (20) @(posedge clock);
        assert (instr_empty) else begin
            check_errors++;
            $display("FAILED extra_instr: expected %b, actual %b", 1'b1, instr_empty);
        end
        assert (rays_sent == RAY_TOTAL) else begin
            check_errors++;
            $display("FAILED rays_sent: expected %0d, actual %0d", RAY_TOTAL, rays_sent);
        end
        assert (saw_full) else begin
            check_errors++;
            $display("ray_full never rose while rays were pushed");
        end
        finish_run();
    end

endmodule

//--- verilog.f
+incdir+common
common/tracer_pkg.sv
rtl/stream_fifo.sv
rtl/tri_mem.sv
streamer/streamer.sv
rtl/ray_stream_top.sv
tests/ray_stream_sva.sv
tests/ray_stream_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    -f verilog.f \
    --top-module ray_stream_tb \
    -Mdir obj_dir \
    -o ray_stream_sim

status=0
./obj_dir/ray_stream_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi
